// ==== rv_pkg.sv ====
/*
  RV32I core shared definitions
  Opcodes, ALU and writeback encodings, instruction word views
*/
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  // Base opcodes, RV32I subset
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus_4} wb_sel_t;

  typedef enum logic [1:0] {fwd_none, fwd_exmem, fwd_memwb} fwd_sel_t;

  // ========================================
  // Instruction word views
  // ========================================
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;   // imm[11:5]
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;   // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;   // Register fields, B/U/J bits
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } instr_t;

endpackage

// ==== mem_bus_if.sv ====
/*
  Requester path to the shared memory port
  Served in the cycle gnt is high, writes land on the next edge
*/
`timescale 1ns/1ps

interface mem_bus_if;
  import rv_pkg::*;

  logic  req;     // Access wanted this cycle
  logic  we;      // Write, data side only
  word_t addr;    // Word aligned byte address
  word_t wdata;
  word_t rdata;   // Combinational, valid while granted
  logic  gnt;     // Served this cycle

  modport requester (output req, we, addr, wdata, input rdata, gnt);
  modport arbiter (input req, we, addr, wdata, output rdata, gnt);

endinterface

// ==== stage_if.sv ====
/*
  Pipeline register bundles
  ID/EX from decode to execute, EX/MEM from execute to memory
*/
`timescale 1ns/1ps

interface idex_if;
  import rv_pkg::*;

  logic       valid;
  word_t      pc;
  word_t      rs1_data;   // Register file value, bypassed
  word_t      rs2_data;
  reg_addr_t  rs1;        // Zero when the field is not a source
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       alu_src;    // Operand B from imm
  logic       op_a_sel;   // Operand A from pc
  logic       branch;
  logic       jump;
  logic       jalr;
  logic [2:0] funct3;     // Branch condition
  logic       mem_read;
  logic       mem_write;
  logic       reg_write;
  wb_sel_t    wb_sel;

  modport source (output valid, pc, rs1_data, rs2_data, rs1, rs2, rd, imm, alu_op,
                  alu_src, op_a_sel, branch, jump, jalr, funct3, mem_read, mem_write,
                  reg_write, wb_sel);
  modport sink (input valid, pc, rs1_data, rs2_data, rs1, rs2, rd, imm, alu_op,
                alu_src, op_a_sel, branch, jump, jalr, funct3, mem_read, mem_write,
                reg_write, wb_sel);

endinterface

interface exmem_if;
  import rv_pkg::*;

  logic      valid;
  word_t     alu_result;   // Also the data address
  word_t     store_data;
  reg_addr_t rd;
  word_t     pc_plus_4;    // Link value
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  wb_sel_t   wb_sel;

  modport source (output valid, alu_result, store_data, rd, pc_plus_4, mem_read,
                  mem_write, reg_write, wb_sel);
  modport sink (input valid, alu_result, store_data, rd, pc_plus_4, mem_read,
                mem_write, reg_write, wb_sel);

endinterface

// ==== fetch_stage.sv ====
/*
  Fetch stage
  PC, instruction request on the shared bus, IF/ID register
*/
`timescale 1ns/1ps

module fetch_stage #(
  parameter rv_pkg::word_t reset_vector = '0
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           stall_load_use,
  input  logic           redirect,
  input  rv_pkg::word_t  redirect_pc,
  mem_bus_if.requester   fetch_bus,
  output logic           if_valid,
  output rv_pkg::word_t  if_pc,
  output rv_pkg::instr_t if_instr
);
  import rv_pkg::*;

  word_t pc;

  // Ask every cycle unless held or redirected
  assign fetch_bus.req   = !stall_load_use && !redirect;
  assign fetch_bus.we    = 1'b0;   // Read only
  assign fetch_bus.addr  = pc;
  assign fetch_bus.wdata = '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc       <= reset_vector;
      if_valid <= 1'b0;
    end else if (redirect) begin   // Taken branch or jump wins
      pc       <= redirect_pc;
      if_valid <= 1'b0;            // Drop the wrong-path word
    end else if (!stall_load_use) begin
      if_valid <= fetch_bus.gnt;   // Refused fetch becomes a bubble
      if (fetch_bus.gnt) begin
        pc <= pc + 32'd4;
      end
    end
  end

  // IF/ID payload, loaded only on an accepted fetch
  always_ff @(posedge clk) begin
    if (fetch_bus.gnt) begin
      if_pc    <= pc;
      if_instr <= fetch_bus.rdata;
    end
  end

endmodule

// ==== decode_stage.sv ====
/*
  Decode stage
  Control and immediates, register file with writeback bypass,
  load-use detection and the ID/EX register
*/
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              if_valid,
  input  rv_pkg::word_t     if_pc,
  input  rv_pkg::instr_t    if_instr,
  input  logic              redirect,
  input  logic              wb_valid,
  input  rv_pkg::reg_addr_t wb_rd,
  input  rv_pkg::word_t     wb_data,
  output logic              stall_load_use,
  idex_if.source            idex
);
  import rv_pkg::*;

  word_t      regs [1:31];   // x0 not stored
  reg_addr_t  rs1, rs2, rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  word_t      rs1_data, rs2_data;
  alu_op_t    alu_op;
  wb_sel_t    wb_sel;
  logic       alu_src, op_a_sel, branch, jump, jalr;
  logic       mem_read, mem_write, reg_write, use_rs1, use_rs2;

  // funct3 to ALU op, alt picks sub or sra
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign rs1    = if_instr.r_fmt.rs1;
  assign rs2    = if_instr.r_fmt.rs2;
  assign rd     = if_instr.r_fmt.rd;
  assign funct3 = if_instr.r_fmt.funct3;
  assign funct7 = if_instr.r_fmt.funct7;

  // Immediates, B/U/J rebuilt from the register view
  assign imm_i = {{20{if_instr.i_fmt.imm12[11]}}, if_instr.i_fmt.imm12};
  assign imm_s = {{20{if_instr.s_fmt.imm_hi[6]}}, if_instr.s_fmt.imm_hi, if_instr.s_fmt.imm_lo};
  assign imm_b = {{20{funct7[6]}}, rd[0], funct7[5:0], rd[4:1], 1'b0};
  assign imm_u = {funct7, rs2, rs1, funct3, 12'h000};
  assign imm_j = {{12{funct7[6]}}, rs1, funct3, rs2[0], funct7[5:0], rs2[4:1], 1'b0};

  // ========================================
  // Control decode
  // ========================================
  always_comb begin
    imm       = imm_i;
    alu_op    = alu_add;
    wb_sel    = wb_alu;
    alu_src   = 1'b1;
    op_a_sel  = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    jalr      = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (if_instr.r_fmt.opcode)
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        reg_write = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        op_a_sel  = 1'b1;   // pc + imm
        reg_write = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        jump      = 1'b1;
        wb_sel    = wb_pc_plus_4;
        reg_write = 1'b1;
      end
      op_jalr: begin
        jump      = 1'b1;
        jalr      = 1'b1;
        wb_sel    = wb_pc_plus_4;
        reg_write = 1'b1;
        use_rs1   = 1'b1;
      end
      op_branch: begin
        imm     = imm_b;
        branch  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      op_load: begin
        mem_read  = 1'b1;
        wb_sel    = wb_mem;
        reg_write = 1'b1;
        use_rs1   = 1'b1;
      end
      op_store: begin
        imm       = imm_s;
        mem_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      op_op_imm: begin
        alu_op    = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);   // srai only
        reg_write = 1'b1;
        use_rs1   = 1'b1;
      end
      op_op: begin
        alu_op    = alu_decode(funct3, funct7[5]);
        alu_src   = 1'b0;
        reg_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      default: ;   // Unknown opcode runs as a no-op
    endcase
  end

  // Register file, same-cycle writeback passes straight through
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1 != '0) rs1_data = (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
    if (rs2 != '0) rs2_data = (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];
  end

  always_ff @(posedge clk) begin
    if (wb_valid) regs[wb_rd] <= wb_data;   // wb_valid implies rd != 0
  end

  // Load in EX feeding this instruction
  assign stall_load_use = if_valid && idex.valid && idex.mem_read && idex.rd != '0 &&
                          ((use_rs1 && idex.rd == rs1) || (use_rs2 && idex.rd == rs2));

  // ========================================
  // ID/EX register
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idex.valid     <= 1'b0;
      idex.branch    <= 1'b0;
      idex.jump      <= 1'b0;
      idex.jalr      <= 1'b0;
      idex.mem_read  <= 1'b0;
      idex.mem_write <= 1'b0;
      idex.reg_write <= 1'b0;
    end else begin
      idex.valid     <= if_valid && !stall_load_use && !redirect;   // Bubble on stall or flush
      idex.branch    <= branch;
      idex.jump      <= jump;
      idex.jalr      <= jalr;
      idex.mem_read  <= mem_read;
      idex.mem_write <= mem_write;
      idex.reg_write <= reg_write;
    end
  end

  always_ff @(posedge clk) begin
    idex.pc       <= if_pc;
    idex.rs1_data <= rs1_data;
    idex.rs2_data <= rs2_data;
    idex.rs1      <= use_rs1 ? rs1 : '0;   // Keeps forwarding off stray fields
    idex.rs2      <= use_rs2 ? rs2 : '0;
    idex.rd       <= rd;
    idex.imm      <= imm;
    idex.alu_op   <= alu_op;
    idex.alu_src  <= alu_src;
    idex.op_a_sel <= op_a_sel;
    idex.funct3   <= funct3;
    idex.wb_sel   <= wb_sel;
  end

endmodule

// ==== execute_stage.sv ====
/*
  Execute stage
  Operand forwarding, ALU, branch decision and target,
  redirect to fetch and the EX/MEM register
*/
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              reset_n,
  idex_if.sink              idex,
  input  logic              wb_valid,
  input  rv_pkg::reg_addr_t wb_rd,
  input  rv_pkg::word_t     wb_data,
  exmem_if.source           exmem,
  output logic              redirect,
  output rv_pkg::word_t     redirect_pc
);
  import rv_pkg::*;

  fwd_sel_t fwd_a, fwd_b;
  word_t    exmem_value, rs1_val, rs2_val;
  word_t    op_a, op_b, alu_result, jalr_sum;
  logic     cond;

  // Nearest older writer wins
  function automatic fwd_sel_t fwd_pick(input reg_addr_t rs);
    if (rs == '0) return fwd_none;
    if (exmem.valid && exmem.reg_write && exmem.rd == rs) return fwd_exmem;
    if (wb_valid && wb_rd == rs) return fwd_memwb;
    return fwd_none;
  endfunction

  assign fwd_a = fwd_pick(idex.rs1);
  assign fwd_b = fwd_pick(idex.rs2);

  // A jump in EX/MEM forwards its link value
  assign exmem_value = (exmem.wb_sel == wb_pc_plus_4) ? exmem.pc_plus_4 : exmem.alu_result;

  always_comb begin
    case (fwd_a)
      fwd_exmem: rs1_val = exmem_value;
      fwd_memwb: rs1_val = wb_data;
      default:   rs1_val = idex.rs1_data;
    endcase
    case (fwd_b)
      fwd_exmem: rs2_val = exmem_value;
      fwd_memwb: rs2_val = wb_data;
      default:   rs2_val = idex.rs2_data;
    endcase
  end

  assign op_a = idex.op_a_sel ? idex.pc : rs1_val;   // AUIPC
  assign op_b = idex.alu_src ? idex.imm : rs2_val;

  // ========================================
  // ALU
  // ========================================
  always_comb begin
    case (idex.alu_op)
      alu_add:  alu_result = op_a + op_b;
      alu_sub:  alu_result = op_a - op_b;
      alu_sll:  alu_result = op_a << op_b[4:0];
      alu_slt:  alu_result = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_result = word_t'(op_a < op_b);
      alu_xor:  alu_result = op_a ^ op_b;
      alu_srl:  alu_result = op_a >> op_b[4:0];
      alu_sra:  alu_result = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_result = op_a | op_b;
      alu_and:  alu_result = op_a & op_b;
      default:  alu_result = op_b;   // LUI
    endcase
  end

  // Branch compare on forwarded operands
  always_comb begin
    case (idex.funct3)
      3'b000:  cond = rs1_val == rs2_val;                     // beq
      3'b001:  cond = rs1_val != rs2_val;                     // bne
      3'b100:  cond = $signed(rs1_val) < $signed(rs2_val);    // blt
      3'b101:  cond = $signed(rs1_val) >= $signed(rs2_val);   // bge
      3'b110:  cond = rs1_val < rs2_val;                      // bltu
      3'b111:  cond = rs1_val >= rs2_val;                     // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum    = rs1_val + idex.imm;
  assign redirect    = idex.valid && (idex.jump || (idex.branch && cond));
  assign redirect_pc = idex.jalr ? {jalr_sum[xlen-1:1], 1'b0} : idex.pc + idex.imm;

  // ========================================
  // EX/MEM register
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      exmem.valid     <= 1'b0;
      exmem.mem_read  <= 1'b0;
      exmem.mem_write <= 1'b0;
      exmem.reg_write <= 1'b0;
    end else begin
      exmem.valid     <= idex.valid;   // Branch itself still retires
      exmem.mem_read  <= idex.mem_read;
      exmem.mem_write <= idex.mem_write;
      exmem.reg_write <= idex.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    exmem.alu_result <= alu_result;
    exmem.store_data <= rs2_val;
    exmem.rd         <= idex.rd;
    exmem.pc_plus_4  <= idex.pc + 32'd4;
    exmem.wb_sel     <= idex.wb_sel;
  end

endmodule

// ==== mem_wb_stage.sv ====
/*
  Memory and writeback stage
  Word load and store over the data bus, MEM/WB register,
  writeback value and valid
*/
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic              clk,
  input  logic              reset_n,
  exmem_if.sink             exmem,
  mem_bus_if.requester      data_bus,
  output logic              wb_valid,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data
);
  import rv_pkg::*;

  word_t   alu_q, load_q, link_q;
  wb_sel_t wb_sel_q;

  // Data access, always granted first
  assign data_bus.req   = exmem.valid && (exmem.mem_read || exmem.mem_write);
  assign data_bus.we    = exmem.valid && exmem.mem_write;
  assign data_bus.addr  = exmem.alu_result;
  assign data_bus.wdata = exmem.store_data;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= exmem.valid && exmem.reg_write && exmem.rd != '0;   // x0 never written
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    wb_rd    <= exmem.rd;
    alu_q    <= exmem.alu_result;
    link_q   <= exmem.pc_plus_4;
    wb_sel_q <= exmem.wb_sel;
    if (data_bus.gnt) load_q <= data_bus.rdata;   // Read word of this cycle
  end

  always_comb begin
    case (wb_sel_q)
      wb_mem:       wb_data = load_q;
      wb_pc_plus_4: wb_data = link_q;
      default:      wb_data = alu_q;
    endcase
  end

endmodule

// ==== mem_arbiter.sv ====
/*
  Shared memory port arbiter
  Fixed priority, data access over instruction fetch
*/
`timescale 1ns/1ps

module mem_arbiter (
  mem_bus_if.arbiter    fetch_bus,
  mem_bus_if.arbiter    data_bus,
  output logic          mem_req,
  output logic          mem_we,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  input  rv_pkg::word_t mem_rdata
);

  // Grants
  assign data_bus.gnt  = data_bus.req;
  assign fetch_bus.gnt = fetch_bus.req && !data_bus.req;   // Fetch yields

  // ========================================
  // External port steering
  // ========================================
  assign mem_req   = data_bus.req || fetch_bus.req;
  assign mem_we    = data_bus.req ? data_bus.we : fetch_bus.we;
  assign mem_addr  = data_bus.req ? data_bus.addr : fetch_bus.addr;
  assign mem_wdata = data_bus.req ? data_bus.wdata : fetch_bus.wdata;

  // Read data to both, gnt tells who owns it
  assign fetch_bus.rdata = mem_rdata;
  assign data_bus.rdata  = mem_rdata;

endmodule

// ==== rv32i_core.sv ====
/*
  Five-stage pipelined RV32I core
  Single shared memory port, retire trace per register write
*/
`timescale 1ns/1ps

module rv32i_core #(
  parameter rv_pkg::word_t reset_vector = '0
) (
  input  logic              clk,
  input  logic              reset_n,
  input  rv_pkg::word_t     mem_rdata,
  output logic              mem_req,
  output logic              mem_we,
  output rv_pkg::word_t     mem_addr,
  output rv_pkg::word_t     mem_wdata,
  output logic              retire_valid,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_data
);
  import rv_pkg::*;

  logic      if_valid;         // IF/ID
  word_t     if_pc;
  instr_t    if_instr;
  logic      redirect;         // From EX
  word_t     redirect_pc;
  logic      stall_load_use;   // From ID
  logic      wb_valid;         // From MEM/WB
  reg_addr_t wb_rd;
  word_t     wb_data;

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();
  idex_if    idex ();
  exmem_if   exmem ();

  // ========================================
  // Stages
  // ========================================
  fetch_stage #(
    .reset_vector(reset_vector)
  ) i_fetch (
    .clk           (clk),
    .reset_n       (reset_n),
    .stall_load_use(stall_load_use),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .fetch_bus     (fetch_bus),
    .if_valid      (if_valid),
    .if_pc         (if_pc),
    .if_instr      (if_instr)
  );

  decode_stage i_decode (
    .clk           (clk),
    .reset_n       (reset_n),
    .if_valid      (if_valid),
    .if_pc         (if_pc),
    .if_instr      (if_instr),
    .redirect      (redirect),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .stall_load_use(stall_load_use),
    .idex          (idex)
  );

  execute_stage i_execute (
    .clk        (clk),
    .reset_n    (reset_n),
    .idex       (idex),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .exmem      (exmem),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

  mem_wb_stage i_mem_wb (
    .clk     (clk),
    .reset_n (reset_n),
    .exmem   (exmem),
    .data_bus(data_bus),
    .wb_valid(wb_valid),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  mem_arbiter i_arbiter (
    .fetch_bus(fetch_bus),
    .data_bus (data_bus),
    .mem_req  (mem_req),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

  // Retire trace is the writeback port
  assign retire_valid = wb_valid;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;

endmodule

// ==== tb_rv32i_core.sv ====
/*
  Testbench for the five-stage RV32I core
  Shared memory model, program table, retire and store checks
*/
`timescale 1ns/1ps

module tb_rv32i_core;

  localparam int max_tests = 8;
  localparam int max_words = 16;
  localparam int max_ret   = 8;
  localparam int ret_limit = 200;   // Cycles allowed per test

  // RV32I opcodes for the encoders
  localparam logic [6:0] opc_imm   = 7'h13;
  localparam logic [6:0] opc_reg   = 7'h33;
  localparam logic [6:0] opc_load  = 7'h03;
  localparam logic [6:0] opc_lui   = 7'h37;
  localparam logic [6:0] opc_auipc = 7'h17;
  localparam logic [6:0] opc_jalr  = 7'h67;

  logic        clk;
  logic        reset_n;
  logic [31:0] mem_rdata;
  logic        mem_req, mem_we;
  logic [31:0] mem_addr, mem_wdata;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  logic [31:0] mem [0:255];            // 1 KiB, word indexed
  logic [31:0] st_log_addr [$];        // Every write seen on the port
  logic [31:0] st_log_data [$];

  // ========================================
  // Program table
  // ========================================
  string       test_name [max_tests];
  logic [31:0] prog [max_tests][max_words];
  logic [31:0] preset [max_tests][2];   // Words at 0x100 and 0x104
  int          n_ret [max_tests];
  logic [4:0]  exp_rd [max_tests][max_ret];
  logic [31:0] exp_val [max_tests][max_ret];
  logic        st_expected [max_tests];
  logic [31:0] st_addr_exp [max_tests];
  logic [31:0] st_data_exp [max_tests];
  int          n_tests, cur, n_words;
  int          n_pass, n_fail;

  rv32i_core #(
    .reset_vector(32'h0000_0000)
  ) i_dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .mem_rdata   (mem_rdata),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // Memory model, combinational read, write on the edge
  assign mem_rdata = mem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (mem_req && mem_we) begin
      mem[mem_addr[9:2]] <= mem_wdata;
      st_log_addr.push_back(mem_addr);
      st_log_data.push_back(mem_wdata);
    end
  end

  // Instruction formats from the RV32I spec
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};   // sw only
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // Table builders
  task automatic new_test(input string name, input logic [31:0] d0, input logic [31:0] d1);
    int w;
    cur = n_tests;
    n_tests++;
    test_name[cur]   = name;
    preset[cur][0]   = d0;
    preset[cur][1]   = d1;
    n_ret[cur]       = 0;
    st_expected[cur] = 1'b0;
    n_words          = 0;
    for (w = 0; w < max_words; w++) prog[cur][w] = '0;   // Zero word runs as a no-op
  endtask

  task automatic add_instr(input logic [31:0] word);
    prog[cur][n_words] = word;
    n_words++;
  endtask

  task automatic expect_retire(input logic [4:0] rd, input logic [31:0] val);
    exp_rd[cur][n_ret[cur]]  = rd;
    exp_val[cur][n_ret[cur]] = val;
    n_ret[cur]++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    st_expected[cur] = 1'b1;
    st_addr_exp[cur] = addr;
    st_data_exp[cur] = data;
  endtask

  task automatic load_memory(input int t);
    int a;
    for (a = 0; a < 256; a++) mem[a] = 32'hbad0_0000 | (a << 2);   // Tagged with own address
    for (a = 0; a < max_words; a++) mem[a] = prog[t][a];
    mem[64] = preset[t][0];
    mem[65] = preset[t][1];
    st_log_addr.delete();
    st_log_data.delete();
  endtask

  // ========================================
  // One table row, reset to last retire
  // ========================================
  task automatic run_test(input int t);
    logic [4:0]  got_rd [$];
    logic [31:0] got_val [$];
    int          cycles, i, n_st;
    logic        ok;
    ok = 1'b1;
    @(posedge clk);
    reset_n <= 1'b0;
    @(posedge clk);
    load_memory(t);                        // Pipeline idle under reset
    repeat (7) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);                        // First cycle out of reset
    assert (mem_req && !mem_we && mem_addr == 32'h0000_0000 && !retire_valid) else begin
      $display("Fail %0t: %s after reset req=%b we=%b addr=%h retire=%b, expected 1 0 0 0",
               $time, test_name[t], mem_req, mem_we, mem_addr, retire_valid);
      ok = 1'b0;
    end
    cycles = 0;
    while (got_rd.size() < n_ret[t] && cycles < ret_limit) begin
      @(negedge clk);                      // Retire outputs settled
      cycles++;
      if (retire_valid) begin
        got_rd.push_back(retire_rd);
        got_val.push_back(retire_data);
      end
    end
    if (got_rd.size() < n_ret[t]) begin
      $display("Test %s timed out after %0d cycles with %0d of %0d retires",
               test_name[t], ret_limit, got_rd.size(), n_ret[t]);
      ok = 1'b0;
    end
    for (i = 0; i < got_rd.size(); i++) begin
      assert (got_rd[i] == exp_rd[t][i] && got_val[i] == exp_val[t][i]) else begin
        $display("Fail %0t: %s retire %0d gave x%0d=%h, expected x%0d=%h", $time,
                 test_name[t], i, got_rd[i], got_val[i], exp_rd[t][i], exp_val[t][i]);
        ok = 1'b0;
      end
    end
    n_st = st_expected[t] ? 1 : 0;
    assert (st_log_addr.size() == n_st) else begin
      $display("Fail %0t: %s saw %0d stores, expected %0d", $time, test_name[t],
               st_log_addr.size(), n_st);
      ok = 1'b0;
    end
    if (n_st == 1 && st_log_addr.size() == 1) begin
      assert (st_log_addr[0] == st_addr_exp[t] && st_log_data[0] == st_data_exp[t]) else begin
        $display("Fail %0t: %s store %h <= %h, expected %h <= %h", $time, test_name[t],
                 st_log_addr[0], st_log_data[0], st_addr_exp[t], st_data_exp[t]);
        ok = 1'b0;
      end
    end
    if (ok) n_pass++;
    else n_fail++;
    $display("Test %s %s", test_name[t], ok ? "ok" : "failed");
  endtask

  initial begin
    int t;
    reset_n = 1'b0;
    n_tests = 0;
    n_pass  = 0;
    n_fail  = 0;

    new_test("alu_chain", 32'h0, 32'h0);   // Back to back forwarding
    add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_imm));      // addi x1, x0, 5
    add_instr(i_type(-12'sd3, 5'd1, 3'b000, 5'd2, opc_imm));    // addi x2, x1, -3
    add_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));         // add  x3, x1, x2
    add_instr(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd4));         // sub  x4, x2, x3
    add_instr(r_type(7'h00, 5'd1, 5'd4, 3'b010, 5'd5));         // slt  x5, x4, x1
    add_instr(r_type(7'h20, 5'd5, 5'd4, 3'b101, 5'd6));         // sra  x6, x4, x5
    add_instr(r_type(7'h00, 5'd3, 5'd6, 3'b100, 5'd7));         // xor  x7, x6, x3
    expect_retire(5'd1, 32'd5);
    expect_retire(5'd2, 32'd2);
    expect_retire(5'd3, 32'd7);
    expect_retire(5'd4, 32'hffff_fffb);
    expect_retire(5'd5, 32'd1);
    expect_retire(5'd6, 32'hffff_fffd);
    expect_retire(5'd7, 32'hffff_fffa);

    new_test("load_use", 32'h1234_5678, 32'h0000_0011);
    add_instr(i_type(12'h100, 5'd0, 3'b000, 5'd1, opc_imm));    // addi x1, x0, 0x100
    add_instr(i_type(12'd0, 5'd1, 3'b010, 5'd2, opc_load));     // lw   x2, 0(x1)
    add_instr(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));         // add  x3, x2, x1
    add_instr(i_type(12'd4, 5'd1, 3'b010, 5'd4, opc_load));     // lw   x4, 4(x1)
    add_instr(r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd5));         // add  x5, x4, x4
    expect_retire(5'd1, 32'h0000_0100);
    expect_retire(5'd2, 32'h1234_5678);
    expect_retire(5'd3, 32'h1234_5778);
    expect_retire(5'd4, 32'h0000_0011);
    expect_retire(5'd5, 32'h0000_0022);

    new_test("store_load", 32'h0, 32'h0);
    add_instr(i_type(12'h100, 5'd0, 3'b000, 5'd1, opc_imm));    // addi x1, x0, 0x100
    add_instr(i_type(12'h02a, 5'd0, 3'b000, 5'd2, opc_imm));    // addi x2, x0, 42
    add_instr(i_type(12'd4, 5'd2, 3'b001, 5'd3, opc_imm));      // slli x3, x2, 4
    add_instr(s_type(12'd8, 5'd3, 5'd1));                       // sw   x3, 8(x1)
    add_instr(i_type(12'd8, 5'd1, 3'b010, 5'd4, opc_load));     // lw   x4, 8(x1)
    expect_retire(5'd1, 32'h0000_0100);
    expect_retire(5'd2, 32'h0000_002a);
    expect_retire(5'd3, 32'h0000_02a0);
    expect_retire(5'd4, 32'h0000_02a0);
    expect_store(32'h0000_0108, 32'h0000_02a0);

    new_test("branches", 32'h0, 32'h0);
    add_instr(i_type(12'd3, 5'd0, 3'b000, 5'd1, opc_imm));      // addi x1, x0, 3
    add_instr(i_type(12'd3, 5'd0, 3'b000, 5'd2, opc_imm));      // addi x2, x0, 3
    add_instr(b_type(13'd12, 5'd2, 5'd1, 3'b000));              // beq  x1, x2, 0x14
    add_instr(i_type(12'd1, 5'd0, 3'b000, 5'd3, opc_imm));      // Shadow slot
    add_instr(i_type(12'd2, 5'd0, 3'b000, 5'd4, opc_imm));      // Shadow slot
    add_instr(b_type(13'd8, 5'd2, 5'd1, 3'b001));               // bne  x1, x2, not taken
    add_instr(i_type(12'd7, 5'd0, 3'b000, 5'd5, opc_imm));      // addi x5, x0, 7
    add_instr(i_type(12'd9, 5'd0, 3'b000, 5'd6, opc_imm));      // addi x6, x0, 9
    expect_retire(5'd1, 32'd3);
    expect_retire(5'd2, 32'd3);
    expect_retire(5'd5, 32'd7);
    expect_retire(5'd6, 32'd9);

    new_test("jumps_upper", 32'h0, 32'h0);
    add_instr(u_type(20'h12345, 5'd1, opc_lui));                // lui   x1, 0x12345
    add_instr(u_type(20'h00001, 5'd2, opc_auipc));              // auipc x2, 1 at 0x04
    add_instr(j_type(21'd12, 5'd3));                            // jal   x3, 0x14
    add_instr(i_type(12'd1, 5'd0, 3'b000, 5'd4, opc_imm));      // Skipped
    add_instr(i_type(12'd2, 5'd0, 3'b000, 5'd4, opc_imm));      // Skipped
    add_instr(i_type(12'h021, 5'd0, 3'b000, 5'd5, opc_imm));    // addi  x5, x0, 0x21
    add_instr(i_type(12'd0, 5'd5, 3'b000, 5'd6, opc_jalr));     // jalr  x6, 0(x5), bit 0 dropped
    add_instr(i_type(12'd1, 5'd0, 3'b000, 5'd7, opc_imm));      // Skipped
    add_instr(i_type(12'd1, 5'd3, 3'b000, 5'd8, opc_imm));      // addi  x8, x3, 1 at 0x20
    expect_retire(5'd1, 32'h1234_5000);
    expect_retire(5'd2, 32'h0000_1004);
    expect_retire(5'd3, 32'h0000_000c);
    expect_retire(5'd5, 32'h0000_0021);
    expect_retire(5'd6, 32'h0000_001c);
    expect_retire(5'd8, 32'h0000_000d);

    new_test("x0_writes", 32'h0, 32'h0);
    add_instr(i_type(12'd5, 5'd0, 3'b000, 5'd0, opc_imm));      // addi x0, x0, 5
    add_instr(i_type(12'd7, 5'd0, 3'b000, 5'd1, opc_imm));      // addi x1, x0, 7
    add_instr(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));         // add  x0, x1, x1
    add_instr(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));         // add  x2, x0, x1
    add_instr(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd3));         // or   x3, x0, x0
    expect_retire(5'd1, 32'd7);
    expect_retire(5'd2, 32'd7);
    expect_retire(5'd3, 32'd0);

    for (t = 0; t < n_tests; t++) run_test(t);

    $display("Tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rv_pkg.sv
mem_bus_if.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
mem_arbiter.sv
rv32i_core.sv
tb_rv32i_core.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - rv_pkg.sv
  - mem_bus_if.sv
  - stage_if.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - mem_wb_stage.sv
  - mem_arbiter.sv
  - rv32i_core.sv
  - target: test
    files:
      - tb_rv32i_core.sv
